// ==== timing_pkg.sv ====
package timing_pkg;

   // Base period counter width.
   // The counter runs modulo the programmed period.
   localparam int sample_period_wi = 8;

   // Width of each downsample period.
   localparam int dsample_wi = 8;

   // Number of downsample branches in the sampler.
   localparam int ds_branches = 3;

   // Start value of every downsample counter.
   // A counter that starts at 1 reads its strobe high out of reset, so the
   // first base strobe also ends the first downsample period.
   localparam int ds_reset_count = 1;

   // Period value treated as the shortest legal base period.
   localparam int min_sample_period = 1;

endpackage

// ==== acq_pkg.sv ====
package acq_pkg;

   // Sample word as delivered by the ADC.
   localparam int adc_wi = 16;

   // Accumulator widths per branch.
   // Each adds headroom over adc_wi for the longest expected dump period.
   localparam int acc0_wi = 24;
   localparam int acc1_wi = 28;
   localparam int acc2_wi = 32;

   // Signed two's complement ADC word.
   typedef logic signed [adc_wi-1:0] adc_word_t;

   // Branch 0 accumulator, up to 256 full-scale samples.
   typedef logic signed [acc0_wi-1:0] acc0_t;

   // Branch 1 accumulator.
   typedef logic signed [acc1_wi-1:0] acc1_t;

   // Branch 2 accumulator.
   typedef logic signed [acc2_wi-1:0] acc2_t;

endpackage

// ==== sample_strobe_if.sv ====
`timescale 1ns/100ps

interface sample_strobe_if;

   logic sample;   // One-cycle base strobe.
   logic ds0_stb;  // Downsample levels, high while count is 1.
   logic ds1_stb;
   logic ds2_stb;

   // Sampler side drives every strobe.
   modport sampler (
      output sample, ds0_stb, ds1_stb, ds2_stb
   );

   // Decimators only listen.
   modport dec (
      input sample, ds0_stb, ds1_stb, ds2_stb
   );

endinterface

// ==== multi_sampler.sv ====
`timescale 1ns/100ps

module multi_sampler
   import timing_pkg::*;
#(
   parameter int sample_period_wi = timing_pkg::sample_period_wi,
   parameter int dsample_wi       = timing_pkg::dsample_wi,
   parameter bit dsample0_en      = 1'b1,
   parameter bit dsample1_en      = 1'b1,
   parameter bit dsample2_en      = 1'b1
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        enable,
   input  logic                        ext_trig,
   input  logic [sample_period_wi-1:0] sample_period,
   input  logic [dsample_wi-1:0]       dsample0_period,
   input  logic [dsample_wi-1:0]       dsample1_period,
   input  logic [dsample_wi-1:0]       dsample2_period,
   sample_strobe_if.sampler            strobes
);

   localparam bit [ds_branches-1:0] ds_en = {dsample2_en, dsample1_en, dsample0_en};

   logic [sample_period_wi-1:0] base_count;
   logic [sample_period_wi-1:0] period_eff;
   logic                        qual_trig;
   logic                        sample_q;

   logic [dsample_wi-1:0]  ds_period [ds_branches];
   logic [ds_branches-1:0] ds_stb;

   assign qual_trig = enable & ext_trig;

   // A zero period would never wrap. Run it as period 1.
   assign period_eff = (sample_period == '0) ?
                       sample_period_wi'(min_sample_period) : sample_period;

   // Base timing. One strobe per period_eff qualified triggers.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         base_count <= '0;
         sample_q   <= 1'b0;
      end else begin
         sample_q <= qual_trig && (base_count == '0);
         if (qual_trig) begin
            // Compare with >= so a shortened period still wraps at once.
            if (base_count >= period_eff - 1'b1)
               base_count <= '0;
            else
               base_count <= base_count + 1'b1;
         end
      end
   end

   assign ds_period[0] = dsample0_period;
   assign ds_period[1] = dsample1_period;
   assign ds_period[2] = dsample2_period;

   // Downsample counters step on the base strobe only.
   for (genvar i = 0; i < ds_branches; i++) begin : g_ds
      if (ds_en[i]) begin : g_on
         logic [dsample_wi-1:0] ds_count;

         always_ff @(posedge clk) begin
            if (!rst_n) begin
               ds_count <= dsample_wi'(ds_reset_count);
            end else if (sample_q) begin
               if (ds_count == dsample_wi'(1))
                  ds_count <= ds_period[i];  // Reload on the last sample.
               else
                  ds_count <= ds_count - 1'b1;
            end
         end

         assign ds_stb[i] = (ds_count == dsample_wi'(1));
      end else begin : g_off
         assign ds_stb[i] = 1'b0;  // Branch removed.
      end
   end

   assign strobes.sample  = sample_q;
   assign strobes.ds0_stb = ds_stb[0];
   assign strobes.ds1_stb = ds_stb[1];
   assign strobes.ds2_stb = ds_stb[2];

endmodule

// ==== boxcar_decimator.sv ====
`timescale 1ns/100ps

module boxcar_decimator
   import acq_pkg::*;
#(
   parameter type acc_t   = logic signed [23:0],
   parameter int  ds_sel  = 0,
   parameter bit  enabled = 1'b1
) (
   input  logic        clk,
   input  logic        rst_n,
   sample_strobe_if.dec strobes,
   input  adc_word_t   adc_data,
   output acc_t        dec_data,
   output logic        dec_valid
);

   if (enabled) begin : g_on
      acc_t acc;
      acc_t sample_ext;
      acc_t dec_data_q;
      logic dec_valid_q;
      logic ds_stb;

      // Pick the downsample strobe this branch follows.
      always_comb begin
         case (ds_sel)
            0:       ds_stb = strobes.ds0_stb;
            1:       ds_stb = strobes.ds1_stb;
            default: ds_stb = strobes.ds2_stb;
         endcase
      end

      assign sample_ext = acc_t'(adc_data);  // Sign extends, adc_data is signed.

      // Accumulate on base strobes, dump at the end of the period.
      always_ff @(posedge clk) begin
         if (!rst_n) begin
            acc         <= '0;
            dec_data_q  <= '0;
            dec_valid_q <= 1'b0;
         end else begin
            dec_valid_q <= 1'b0;
            if (strobes.sample) begin
               if (ds_stb) begin
                  // Last sample goes straight into the output sum.
                  dec_data_q  <= acc + sample_ext;
                  acc         <= '0;
                  dec_valid_q <= 1'b1;
               end else begin
                  acc <= acc + sample_ext;
               end
            end
         end
      end

      assign dec_data  = dec_data_q;   // Held until the next dump.
      assign dec_valid = dec_valid_q;
   end else begin : g_off
      // No accumulator in a removed branch.
      assign dec_data  = '0;
      assign dec_valid = 1'b0;
   end

endmodule

// ==== acq_top.sv ====
`timescale 1ns/100ps

module acq_top
   import timing_pkg::*;
   import acq_pkg::*;
#(
   parameter int sample_period_wi = timing_pkg::sample_period_wi,
   parameter int dsample_wi       = timing_pkg::dsample_wi,
   parameter bit dsample0_en      = 1'b1,
   parameter bit dsample1_en      = 1'b1,
   parameter bit dsample2_en      = 1'b1
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        enable,
   input  logic                        ext_trig,
   input  adc_word_t                   adc_data,
   input  logic [sample_period_wi-1:0] sample_period,
   input  logic [dsample_wi-1:0]       dsample0_period,
   input  logic [dsample_wi-1:0]       dsample1_period,
   input  logic [dsample_wi-1:0]       dsample2_period,
   output logic                        sample_out,
   output acc0_t                       dec0_data,
   output logic                        dec0_valid,
   output acc1_t                       dec1_data,
   output logic                        dec1_valid,
   output acc2_t                       dec2_data,
   output logic                        dec2_valid
);

   sample_strobe_if strobes ();

   // Strobe generation from the qualified trigger.
   multi_sampler #(
      .sample_period_wi (sample_period_wi),
      .dsample_wi       (dsample_wi),
      .dsample0_en      (dsample0_en),
      .dsample1_en      (dsample1_en),
      .dsample2_en      (dsample2_en)
   ) u_sampler (
      .clk             (clk),
      .rst_n           (rst_n),
      .enable          (enable),
      .ext_trig        (ext_trig),
      .sample_period   (sample_period),
      .dsample0_period (dsample0_period),
      .dsample1_period (dsample1_period),
      .dsample2_period (dsample2_period),
      .strobes         (strobes.sampler)
   );

   // One decimator per downsample branch.
   boxcar_decimator #(
      .acc_t   (acc0_t),
      .ds_sel  (0),
      .enabled (dsample0_en)
   ) u_dec0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .strobes   (strobes.dec),
      .adc_data  (adc_data),
      .dec_data  (dec0_data),
      .dec_valid (dec0_valid)
   );

   boxcar_decimator #(
      .acc_t   (acc1_t),
      .ds_sel  (1),
      .enabled (dsample1_en)
   ) u_dec1 (
      .clk       (clk),
      .rst_n     (rst_n),
      .strobes   (strobes.dec),
      .adc_data  (adc_data),
      .dec_data  (dec1_data),
      .dec_valid (dec1_valid)
   );

   boxcar_decimator #(
      .acc_t   (acc2_t),
      .ds_sel  (2),
      .enabled (dsample2_en)
   ) u_dec2 (
      .clk       (clk),
      .rst_n     (rst_n),
      .strobes   (strobes.dec),
      .adc_data  (adc_data),
      .dec_data  (dec2_data),
      .dec_valid (dec2_valid)
   );

   assign sample_out = strobes.sample;  // Base strobe for downstream logic.

endmodule

// ==== tb_acq_top.sv ====
`timescale 1ns/100ps

module tb_acq_top
   import timing_pkg::*;
   import acq_pkg::*;
();

   // Test lengths in clock cycles.
   localparam int reset_len = 10;
   localparam int t1_len    = 20;
   localparam int t2_len    = 300;
   localparam int t2_off    = 50;
   localparam int t3_len    = 60;
   localparam int t4_len    = 400;
   localparam int t5_pre    = 40;
   localparam int t5_rst    = 3;
   localparam int max_cycles = 3 * reset_len + t1_len + t2_len + t2_off + t3_len
                             + t4_len + t5_pre + t5_rst + t3_len + 200;

   logic                        clk = 1'b0;
   logic                        rst_n;
   logic                        enable;
   logic                        ext_trig;
   adc_word_t                   adc_data;
   logic [sample_period_wi-1:0] sample_period;
   logic [dsample_wi-1:0]       dsample0_period;
   logic [dsample_wi-1:0]       dsample1_period;
   logic [dsample_wi-1:0]       dsample2_period;
   logic                        sample_out;
   acc0_t                       dec0_data;
   logic                        dec0_valid;
   acc1_t                       dec1_data;
   logic                        dec1_valid;
   acc2_t                       dec2_data;
   logic                        dec2_valid;

   int seed = 96262;
   int errors = 0;
   int checks = 0;
   int tests_run = 0;
   int tests_ok = 0;
   int cycle_count = 0;

   // Model state after the latest rising edge.
   int     m_base_count;
   bit     m_sample;
   int     m_ds_count [3];
   longint m_acc [3];
   longint m_dec_data [3];
   bit     m_dec_valid [3];

   acq_top UUT (
      .clk             (clk),
      .rst_n           (rst_n),
      .enable          (enable),
      .ext_trig        (ext_trig),
      .adc_data        (adc_data),
      .sample_period   (sample_period),
      .dsample0_period (dsample0_period),
      .dsample1_period (dsample1_period),
      .dsample2_period (dsample2_period),
      .sample_out      (sample_out),
      .dec0_data       (dec0_data),
      .dec0_valid      (dec0_valid),
      .dec1_data       (dec1_data),
      .dec1_valid      (dec1_valid),
      .dec2_data       (dec2_data),
      .dec2_valid      (dec2_valid)
   );

   always #2 clk = ~clk;  // 4 ns period.

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= max_cycles) begin
         $display("Run stopped: no finish after %0d cycles", cycle_count);
         $display("tests failed");
         $finish;
      end
   end

   function automatic int acc_width(input int k);
      case (k)
         0:       return acc0_wi;
         1:       return acc1_wi;
         default: return acc2_wi;
      endcase
   endfunction

   // Two's complement wrap to the accumulator width.
   function automatic longint wrap_to(input longint v, input int w);
      longint m;
      m = v <<< (64 - w);
      return m >>> (64 - w);
   endfunction

   task automatic check_val(input string name, input longint got, input longint exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   // Next state of sampler and decimators from the current inputs.
   task automatic model_step();
      int                  per;
      bit                  qual;
      bit                  new_sample;
      bit                  ds_hit [3];
      logic [dsample_wi-1:0] dp [3];
      longint              ext;
      int                  k;
      if (!rst_n) begin
         m_base_count = 0;
         m_sample     = 1'b0;
         for (k = 0; k < 3; k++) begin
            m_ds_count[k]  = ds_reset_count;
            m_acc[k]       = 0;
            m_dec_data[k]  = 0;
            m_dec_valid[k] = 1'b0;
         end
      end else begin
         qual = enable && ext_trig;
         per  = (sample_period == '0) ? 1 : int'(sample_period);
         ext  = longint'(adc_data);
         dp[0] = dsample0_period;
         dp[1] = dsample1_period;
         dp[2] = dsample2_period;
         for (k = 0; k < 3; k++) begin
            ds_hit[k]      = (m_ds_count[k] == 1);
            m_dec_valid[k] = 1'b0;
            if (m_sample) begin
               if (ds_hit[k]) begin  // End of period dumps the sum.
                  m_dec_data[k]  = wrap_to(m_acc[k] + ext, acc_width(k));
                  m_acc[k]       = 0;
                  m_dec_valid[k] = 1'b1;
                  m_ds_count[k]  = int'(dp[k]);
               end else begin
                  m_acc[k]      = wrap_to(m_acc[k] + ext, acc_width(k));
                  m_ds_count[k] = m_ds_count[k] - 1;
               end
            end
         end
         new_sample = qual && (m_base_count == 0);
         if (qual)
            m_base_count = (m_base_count + 1) % per;
         m_sample = new_sample;
      end
   endtask

   task automatic compare_all();
      check_val("sample_out", longint'(sample_out), longint'(m_sample));
      check_val("dec0_valid", longint'(dec0_valid), longint'(m_dec_valid[0]));
      check_val("dec1_valid", longint'(dec1_valid), longint'(m_dec_valid[1]));
      check_val("dec2_valid", longint'(dec2_valid), longint'(m_dec_valid[2]));
      check_val("dec0_data", longint'(dec0_data), m_dec_data[0]);
      check_val("dec1_data", longint'(dec1_data), m_dec_data[1]);
      check_val("dec2_data", longint'(dec2_data), m_dec_data[2]);
   endtask

   // Called on a falling edge after inputs are set. Returns on the next one.
   task automatic tick();
      model_step();
      @(negedge clk);
      compare_all();
   endtask

   task automatic apply_reset(input int cycles);
      rst_n = 1'b0;
      repeat (cycles) tick();
      rst_n = 1'b1;
   endtask

   task automatic random_inputs(input bit extremes);
      int r;
      r = $random(seed);
      ext_trig = r[0];
      r = $random(seed);
      adc_data = r[15:0];
      if (extremes && r[17:16] == 2'd0)
         adc_data = 16'sh7FFF;  // Full scale positive.
      else if (extremes && r[17:16] == 2'd1)
         adc_data = 16'sh8000;
   endtask

   task automatic finish_test(input string name, input int err_before);
      tests_run++;
      if (errors == err_before) begin
         tests_ok++;
         $display("Test %s: ok", name);
      end else begin
         $display("Test %s: %0d errors", name, errors - err_before);
      end
   endtask

   task automatic setup_dump_inputs();
      enable          = 1'b1;
      ext_trig        = 1'b1;
      sample_period   = sample_period_wi'(2);
      dsample0_period = dsample_wi'(1);
      dsample1_period = dsample_wi'(3);
      dsample2_period = dsample_wi'(7);
   endtask

   // Valid pulses must land on base strobes 1, 1+P, 1+2P and so on.
   task automatic check_dump_rate(input int cycles);
      int n;
      int k;
      bit seen;
      int pers [3];
      logic v [3];
      pers[0] = 1;
      pers[1] = 3;
      pers[2] = 7;
      n = 0;
      seen = 1'b0;
      repeat (cycles) begin
         random_inputs(1'b0);
         ext_trig = 1'b1;
         tick();
         if (seen)
            n++;
         v[0] = dec0_valid;
         v[1] = dec1_valid;
         v[2] = dec2_valid;
         for (k = 0; k < 3; k++)
            check_val($sformatf("dec%0d_valid", k), longint'(v[k]),
                      longint'(seen && ((n - 1) % pers[k] == 0)));
         seen = sample_out;
      end
      check_val("base strobe count above 7", longint'(n > 7), 1);
   endtask

   initial begin
      int i;
      int err_mark;
      int r;
      int dumps;
      rst_n           = 1'b0;
      enable          = 1'b0;
      ext_trig        = 1'b0;
      adc_data        = '0;
      sample_period   = sample_period_wi'(5);
      dsample0_period = dsample_wi'(1);
      dsample1_period = dsample_wi'(3);
      dsample2_period = dsample_wi'(7);
      apply_reset(reset_len);

      // Steady trigger with period 5.
      err_mark = errors;
      enable   = 1'b1;
      ext_trig = 1'b1;
      for (i = 0; i < t1_len; i++) begin
         tick();
         check_val("sample_out", longint'(sample_out), longint'(i % 5 == 0));
      end
      finish_test("1 base strobe steady", err_mark);

      // Random trigger and periods followed by enable low.
      err_mark = errors;
      for (i = 0; i < t2_len; i++) begin
         random_inputs(1'b0);
         r = $random(seed);
         if (m_base_count == 0 && r[2:0] == 3'd0)
            sample_period = sample_period_wi'((r >> 3) & 7);  // Zero runs as one.
         if (r[7:4] == 4'd0)
            dsample1_period = dsample_wi'(((r >> 8) & 7) + 1);
         tick();
      end
      enable = 1'b0;
      for (i = 0; i < t2_off; i++) begin
         random_inputs(1'b0);
         tick();
         check_val("sample_out", longint'(sample_out), 0);
      end
      finish_test("2 base strobe random", err_mark);

      // Dump rates 1, 3 and 7.
      err_mark = errors;
      setup_dump_inputs();
      apply_reset(reset_len);
      check_dump_rate(t3_len);
      finish_test("3 downsample rates", err_mark);

      // Sums of random data with extremes.
      err_mark = errors;
      enable          = 1'b1;
      sample_period   = sample_period_wi'(2);
      dsample0_period = dsample_wi'(2);
      dsample1_period = dsample_wi'(5);
      dsample2_period = dsample_wi'(4);
      apply_reset(reset_len);
      dumps = 0;
      for (i = 0; i < t4_len; i++) begin
         random_inputs(1'b1);
         tick();
         if (dec2_valid)
            dumps++;
      end
      check_val("dec2 dump count above 3", longint'(dumps > 3), 1);
      finish_test("4 decimated sums", err_mark);

      // Reset in the middle of a run.
      err_mark = errors;
      for (i = 0; i < t5_pre; i++) begin
         random_inputs(1'b1);
         tick();
      end
      setup_dump_inputs();
      apply_reset(t5_rst);
      check_val("dec0_data", longint'(dec0_data), 0);
      check_val("dec1_data", longint'(dec1_data), 0);
      check_val("dec2_data", longint'(dec2_data), 0);
      check_dump_rate(t3_len);
      finish_test("5 mid-run reset", err_mark);

      $display("%0d checks, %0d errors, %0d of %0d tests clean",
               checks, errors, tests_ok, tests_run);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// ==== verilog.f ====
timing_pkg.sv
acq_pkg.sv
sample_strobe_if.sv
multi_sampler.sv
boxcar_decimator.sv
acq_top.sv
tb_acq_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the acquisition testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing -j 0 \
   --top-module tb_acq_top \
   -f verilog.f \
   --Mdir obj_dir \
   -o sim_acq

./obj_dir/sim_acq > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
   echo "Simulation reported failures"
   exit 1
fi

echo "Simulation clean"
exit 0
